// File: list.f
rtl/ctrlport_pkg.sv
rtl/regfile_pkg.sv
rtl/ctrlport_combiner.sv
rtl/ctrlport_reg_slave.sv
rtl/ctrlport_subsystem.sv
test/ctrlport_assertions.sv
test/tb_ctrlport_subsystem.sv

// File: Bender.yml
package:
  name: ctrlport_subsystem

sources:
  - files:
      - rtl/ctrlport_pkg.sv
      - rtl/regfile_pkg.sv
      - rtl/ctrlport_combiner.sv
      - rtl/ctrlport_reg_slave.sv
      - rtl/ctrlport_subsystem.sv
  - target: test
    files:
      - test/ctrlport_assertions.sv
      - test/tb_ctrlport_subsystem.sv

// File: test/tb_ctrlport_subsystem.sv
// Testbench for the control-port register subsystem
`timescale 1ns/100ps
`default_nettype none

module tb_ctrlport_subsystem;

  import ctrlport_pkg::*;
  import regfile_pkg::*;

  localparam int NUM_TESTS = 5;

  logic                             ctrlport_clk;
  logic                             ctrlport_rst;
  logic [NUM_MASTERS-1:0]           s_req_wr;
  logic [NUM_MASTERS-1:0]           s_req_rd;
  logic [NUM_MASTERS*ADDR_W-1:0]    s_req_addr;
  logic [NUM_MASTERS*DATA_W-1:0]    s_req_data;
  logic [NUM_MASTERS*BYTE_EN_W-1:0] s_req_byte_en;
  logic [NUM_MASTERS-1:0]           s_req_has_time;
  logic [NUM_MASTERS-1:0]           s_resp_ack;
  logic [NUM_MASTERS*STATUS_W-1:0]  s_resp_status;
  logic [NUM_MASTERS*DATA_W-1:0]    s_resp_data;

  // Reference copy of the register file with the ID in word 0
  logic [31:0] model [8];
  logic [31:0] lfsr_state;

  ctrlport_subsystem dut (.*);

  initial begin
    ctrlport_clk = 1'b0;
    forever #2 ctrlport_clk = ~ctrlport_clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else abort_run($sformatf("mismatch in %s: expected %h, actual %h", name, expected, actual));
  endtask

  // Galois LFSR that steps once for every bit handed out
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value[i]   = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return value;
  endfunction

  // Status rules in priority order are timed, range, then a write to the ID word
  function automatic logic [1:0] expected_status(input logic wr, input logic [19:0] addr,
                                                 input logic has_time);
    return has_time ? STS_TSERR :
           (addr[19:5] != '0) ? STS_CMDERR :
           (wr && (addr[4:2] == 3'd0)) ? STS_CMDERR : STS_OKAY;
  endfunction

  task automatic update_model(input logic [19:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        model[addr[4:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // Puts one request of master m on the inputs and leaves the strobe for the caller to clear
  task automatic drive_request(input int m, input logic wr, input logic [19:0] addr,
                               input logic [31:0] data, input logic [3:0] be, input logic ht);
    s_req_wr[m]                    = wr;
    s_req_rd[m]                    = !wr;
    s_req_addr[m*ADDR_W +: ADDR_W] = addr;
    s_req_data[m*DATA_W +: DATA_W] = data;
    s_req_byte_en[m*4 +: 4]        = be;
    s_req_has_time[m]              = ht;
  endtask

  // Runs one request from master m and checks the answer against the model
  task automatic transact(input string name, input int m, input logic wr,
                          input logic [19:0] addr, input logic [31:0] data,
                          input logic [3:0] be, input logic ht);
    logic [1:0]  exp_status;
    logic [31:0] exp_data;
    exp_status = expected_status(wr, addr, ht);
    exp_data   = (!wr && (exp_status == STS_OKAY)) ? model[addr[4:2]] : 32'h0;
    @(negedge ctrlport_clk);
    drive_request(m, wr, addr, data, be, ht);
    @(negedge ctrlport_clk);
    s_req_wr = '0;
    s_req_rd = '0;
    while (!s_resp_ack[m]) @(negedge ctrlport_clk);
    check_value({name, " status"}, exp_status, s_resp_status[m*STATUS_W +: STATUS_W]);
    check_value({name, " data"}, exp_data, s_resp_data[m*DATA_W +: DATA_W]);
    if (wr && (exp_status == STS_OKAY)) begin
      update_model(addr, data, be);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic test_reset_state();
    repeat (10) begin
      @(negedge ctrlport_clk);
      check_value("reset ack", '0, s_resp_ack);
    end
    for (int w = 0; w < REG_COUNT; w++) begin
      transact("reset read", w % NUM_MASTERS, 1'b0, 20'(w * 4), '0, '0, 1'b0);
    end
  endtask

  // Written by one master and read back by the next one
  task automatic test_byte_enables();
    logic [31:0] data;
    logic [3:0]  be;
    for (int w = 1; w < REG_COUNT; w++) begin
      data = random_bits(32);
      be   = random_bits(4);
      transact("byte enable write", w % NUM_MASTERS, 1'b1, 20'(w * 4), data, be, 1'b0);
      transact("byte enable read", (w + 1) % NUM_MASTERS, 1'b0, 20'(w * 4), '0, '0, 1'b0);
    end
  endtask

  task automatic test_errors();
    transact("id write", 1, 1'b1, 20'h0_0000, random_bits(32), 4'hF, 1'b0);
    transact("id read", 2, 1'b0, 20'h0_0000, '0, '0, 1'b0);
    transact("range read", 0, 1'b0, 20'h0_0024, '0, '0, 1'b0);
    transact("range write", 1, 1'b1, 20'h1_0008, random_bits(32), 4'hF, 1'b0);
    transact("timed write", 2, 1'b1, 20'h0_000C, random_bits(32), 4'hF, 1'b1);
    transact("timed read back", 0, 1'b0, 20'h0_000C, '0, '0, 1'b0);
  endtask

  // All masters strobe writes to words 4 to 6 in the same cycle
  task automatic test_concurrent();
    int          acks [NUM_MASTERS];
    int          extra;
    logic        all_acked;
    logic [31:0] data;
    @(negedge ctrlport_clk);
    for (int m = 0; m < NUM_MASTERS; m++) begin
      acks[m] = 0;
      data    = random_bits(32);
      drive_request(m, 1'b1, 20'((m + 4) * 4), data, 4'hF, 1'b0);
      update_model(20'((m + 4) * 4), data, 4'hF);
    end
    extra = 0;
    // Keep counting a few cycles past the last ack to catch a second one
    while (extra < 10) begin
      @(negedge ctrlport_clk);
      s_req_wr  = '0;
      all_acked = 1'b1;
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if (s_resp_ack[m]) begin
          acks[m]++;
          check_value("concurrent status", expected_status(1'b1, 20'((m + 4) * 4), 1'b0),
                      s_resp_status[m*STATUS_W +: STATUS_W]);
        end
        all_acked = all_acked && (acks[m] > 0);
      end
      if (all_acked) begin
        extra++;
      end
    end
    for (int m = 0; m < NUM_MASTERS; m++) begin
      check_value("concurrent ack count", 1, acks[m]);
      transact("concurrent read", (m + 1) % NUM_MASTERS, 1'b0, 20'((m + 4) * 4), '0, '0, 1'b0);
    end
  endtask

  // Masters 0 and 1 re-issue reads right after each ack
  task automatic test_fairness();
    int acks [2];
    int last;
    acks = '{0, 0};
    last = -1;
    @(negedge ctrlport_clk);
    drive_request(0, 1'b0, 20'h0_0004, '0, '0, 1'b0);
    drive_request(1, 1'b0, 20'h0_0008, '0, '0, 1'b0);
    while (acks[0] + acks[1] < 16) begin
      @(negedge ctrlport_clk);
      s_req_rd = '0;
      for (int m = 0; m < 2; m++) begin
        if (s_resp_ack[m]) begin
          assert (m != last)
            else abort_run($sformatf("master %0d got two acks while master %0d waited", m, 1 - m));
          check_value("fairness data", model[m + 1], s_resp_data[m*DATA_W +: DATA_W]);
          last = m;
          acks[m]++;
          if (acks[m] < 8) begin
            s_req_rd[m] = 1'b1;
          end
        end
      end
    end
  endtask

  // Watchdog allows 200 cycles per test plus a margin
  initial begin
    repeat (NUM_TESTS * 200 + 100) @(posedge ctrlport_clk);
    abort_run("timeout: the tests did not finish within the cycle limit");
  end

  // Ends the run when the checker inside the combiner sees a broken protocol rule
  initial begin
    wait (dut.u_combiner.u_assertions.rule_broken === 1'b1);
    abort_run("a combiner protocol assertion failed");
  end

  initial begin
    ctrlport_rst   = 1'b1;
    s_req_wr       = '0;
    s_req_rd       = '0;
    s_req_addr     = '0;
    s_req_data     = '0;
    s_req_byte_en  = '0;
    s_req_has_time = '0;
    lfsr_state     = 32'h4ff3_ce14;
    model[0]       = 32'hC0DE_0001;
    for (int w = 1; w < 8; w++) begin
      model[w] = '0;
    end
    repeat (4) @(negedge ctrlport_clk);
    ctrlport_rst = 1'b0;
    test_reset_state();
    test_byte_enables();
    test_errors();
    test_concurrent();
    test_fairness();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/ctrlport_assertions.sv
// Combiner protocol assertions
`timescale 1ns/100ps
`default_nettype none

module ctrlport_assertions #(
  parameter int NUM_MASTERS = 2
) (
  input logic                   ctrlport_clk,
  input logic                   ctrlport_rst,
  input logic                   m_req_wr,
  input logic                   m_req_rd,
  input logic                   m_resp_ack,
  input logic [NUM_MASTERS-1:0] s_resp_ack
);

  // High from a forward strobe until the slave acks it
  logic outstanding;
  // Raised by the first broken rule and never cleared
  logic rule_broken = 1'b0;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      outstanding <= 1'b0;
    end else if (m_req_wr || m_req_rd) begin
      outstanding <= 1'b1;
    end else if (m_resp_ack) begin
      outstanding <= 1'b0;
    end
  end

  // A forward request is either a read or a write
  assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    !(m_req_wr && m_req_rd))
    else begin
      $error("combiner drove a read and a write strobe together");
      rule_broken = 1'b1;
    end

  // Each slave ack reaches exactly one master in the following cycle
  assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    $onehot0(s_resp_ack) && ((s_resp_ack != '0) == $past(m_resp_ack)))
    else begin
      $error("master acks do not match a single slave ack of the previous cycle");
      rule_broken = 1'b1;
    end

  // Only one request may be in flight toward the slave
  assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    (m_req_wr || m_req_rd) |-> !outstanding)
    else begin
      $error("new forward strobe before the slave acked the previous one");
      rule_broken = 1'b1;
    end

endmodule

bind ctrlport_combiner ctrlport_assertions #(
  .NUM_MASTERS (NUM_MASTERS)
) u_assertions (
  .ctrlport_clk (ctrlport_clk),
  .ctrlport_rst (ctrlport_rst),
  .m_req_wr     (m_req_wr),
  .m_req_rd     (m_req_rd),
  .m_resp_ack   (m_resp_ack),
  .s_resp_ack   (s_resp_ack)
);

`default_nettype wire

// File: rtl/ctrlport_subsystem.sv
// Control-port register subsystem top level
`timescale 1ns/100ps
`default_nettype none

module ctrlport_subsystem (
  input  logic ctrlport_clk,
  input  logic ctrlport_rst,

  // Master requests, flattened per master
  input  logic [ctrlport_pkg::NUM_MASTERS-1:0]                          s_req_wr,
  input  logic [ctrlport_pkg::NUM_MASTERS-1:0]                          s_req_rd,
  input  logic [ctrlport_pkg::NUM_MASTERS*ctrlport_pkg::ADDR_W-1:0]     s_req_addr,
  input  logic [ctrlport_pkg::NUM_MASTERS*ctrlport_pkg::DATA_W-1:0]     s_req_data,
  input  logic [ctrlport_pkg::NUM_MASTERS*ctrlport_pkg::BYTE_EN_W-1:0]  s_req_byte_en,
  input  logic [ctrlport_pkg::NUM_MASTERS-1:0]                          s_req_has_time,
  // Master responses
  output logic [ctrlport_pkg::NUM_MASTERS-1:0]                          s_resp_ack,
  output logic [ctrlport_pkg::NUM_MASTERS*ctrlport_pkg::STATUS_W-1:0]   s_resp_status,
  output logic [ctrlport_pkg::NUM_MASTERS*ctrlport_pkg::DATA_W-1:0]     s_resp_data
);

  import ctrlport_pkg::*;

  // Single request path between the combiner and the register file
  logic              m_req_wr;
  logic              m_req_rd;
  ctrlport_addr_t    m_req_addr;
  ctrlport_data_t    m_req_data;
  ctrlport_byte_en_t m_req_byte_en;
  logic              m_req_has_time;
  logic              m_resp_ack;
  ctrlport_status_t  m_resp_status;
  ctrlport_data_t    m_resp_data;

  ctrlport_combiner #(
    .NUM_MASTERS (NUM_MASTERS)
  ) u_combiner (
    .ctrlport_clk   (ctrlport_clk),
    .ctrlport_rst   (ctrlport_rst),
    .s_req_wr       (s_req_wr),
    .s_req_rd       (s_req_rd),
    .s_req_addr     (s_req_addr),
    .s_req_data     (s_req_data),
    .s_req_byte_en  (s_req_byte_en),
    .s_req_has_time (s_req_has_time),
    .s_resp_ack     (s_resp_ack),
    .s_resp_status  (s_resp_status),
    .s_resp_data    (s_resp_data),
    .m_req_wr       (m_req_wr),
    .m_req_rd       (m_req_rd),
    .m_req_addr     (m_req_addr),
    .m_req_data     (m_req_data),
    .m_req_byte_en  (m_req_byte_en),
    .m_req_has_time (m_req_has_time),
    .m_resp_ack     (m_resp_ack),
    .m_resp_status  (m_resp_status),
    .m_resp_data    (m_resp_data)
  );

  ctrlport_reg_slave u_reg_slave (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (m_req_wr),
    .req_rd       (m_req_rd),
    .req_addr     (m_req_addr),
    .req_data     (m_req_data),
    .req_byte_en  (m_req_byte_en),
    .req_has_time (m_req_has_time),
    .resp_ack     (m_resp_ack),
    .resp_status  (m_resp_status),
    .resp_data    (m_resp_data)
  );

endmodule

`default_nettype wire

// File: rtl/ctrlport_reg_slave.sv
// Control-port register file slave
`timescale 1ns/100ps
`default_nettype none

module ctrlport_reg_slave (
  input  logic                            ctrlport_clk,
  input  logic                            ctrlport_rst,

  // Request from the combiner
  input  logic                            req_wr,
  input  logic                            req_rd,
  input  ctrlport_pkg::ctrlport_addr_t    req_addr,
  input  ctrlport_pkg::ctrlport_data_t    req_data,
  input  ctrlport_pkg::ctrlport_byte_en_t req_byte_en,
  input  logic                            req_has_time,

  // Response, valid in the cycle after the strobe
  output logic                            resp_ack,
  output ctrlport_pkg::ctrlport_status_t  resp_status,
  output ctrlport_pkg::ctrlport_data_t    resp_data
);

  import ctrlport_pkg::*;
  import regfile_pkg::*;

  // Words 1 to 7 are writable, word 0 comes from the ID constant
  ctrlport_data_t   regs [1:REG_COUNT-1];

  reg_index_t       req_index;
  logic             addr_in_range;
  ctrlport_status_t req_status;
  ctrlport_data_t   read_word;

  // ----------------------------------------
  // Request decode
  // ----------------------------------------

  assign req_index     = req_addr[REG_BYTE_BITS +: REG_WORD_BITS];
  // Anything above the register window is refused
  assign addr_in_range = (req_addr[ADDR_W-1:REG_BYTE_BITS+REG_WORD_BITS] == '0);

  // Checks in priority order: timed, range, then write to the ID word
  always_comb begin
    if (req_has_time) begin
      req_status = STS_TSERR;
    end else if (!addr_in_range) begin
      req_status = STS_CMDERR;
    end else if (req_wr && (req_index == REG_ID_WORD)) begin
      req_status = STS_CMDERR;
    end else begin
      req_status = STS_OKAY;
    end
  end

  assign read_word = (req_index == REG_ID_WORD) ? REG_ID_VALUE : regs[req_index];

  // ----------------------------------------
  // Register array and response
  // ----------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack <= 1'b0;
      for (int r = 1; r < REG_COUNT; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // Every strobe gets exactly one ack, refused or not
      resp_ack <= req_wr || req_rd;
      if (req_wr && (req_status == STS_OKAY)) begin
        for (int b = 0; b < BYTE_EN_W; b++) begin
          if (req_byte_en[b]) begin
            regs[req_index][8*b +: 8] <= req_data[8*b +: 8];
          end
        end
      end
    end
  end

  // Failed reads and all writes answer with zero data
  always_ff @(posedge ctrlport_clk) begin
    resp_status <= req_status;
    if (req_rd && (req_status == STS_OKAY)) begin
      resp_data <= read_word;
    end else begin
      resp_data <= '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ctrlport_combiner.sv
// Round-robin control-port combiner
`timescale 1ns/100ps
`default_nettype none

module ctrlport_combiner #(
  parameter int NUM_MASTERS = 2
) (
  input  logic                                           ctrlport_clk,
  input  logic                                           ctrlport_rst,

  // Requests from the masters, flattened with master 0 in the low bits
  input  logic [NUM_MASTERS-1:0]                         s_req_wr,
  input  logic [NUM_MASTERS-1:0]                         s_req_rd,
  input  logic [NUM_MASTERS*ctrlport_pkg::ADDR_W-1:0]    s_req_addr,
  input  logic [NUM_MASTERS*ctrlport_pkg::DATA_W-1:0]    s_req_data,
  input  logic [NUM_MASTERS*ctrlport_pkg::BYTE_EN_W-1:0] s_req_byte_en,
  input  logic [NUM_MASTERS-1:0]                         s_req_has_time,
  // Responses to the masters
  output logic [NUM_MASTERS-1:0]                         s_resp_ack,
  output logic [NUM_MASTERS*ctrlport_pkg::STATUS_W-1:0]  s_resp_status,
  output logic [NUM_MASTERS*ctrlport_pkg::DATA_W-1:0]    s_resp_data,

  // Single request toward the slave
  output logic                                           m_req_wr,
  output logic                                           m_req_rd,
  output ctrlport_pkg::ctrlport_addr_t                   m_req_addr,
  output ctrlport_pkg::ctrlport_data_t                   m_req_data,
  output ctrlport_pkg::ctrlport_byte_en_t                m_req_byte_en,
  output logic                                           m_req_has_time,
  // Response from the slave
  input  logic                                           m_resp_ack,
  input  ctrlport_pkg::ctrlport_status_t                 m_resp_status,
  input  ctrlport_pkg::ctrlport_data_t                   m_resp_data
);

  import ctrlport_pkg::*;

  // Width of the selection counter, kept at one bit for a single master
  localparam int unsigned SEL_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

  // Scan for a valid slot, load it onto the output, then wait for the ack
  typedef enum logic [1:0] {
    ARB_SCAN,
    ARB_LOAD,
    ARB_WAIT
  } arb_state_t;

  arb_state_t        arb_state;
  logic [SEL_W-1:0]  sel;
  logic [SEL_W-1:0]  sel_inc;
  logic              slave_done;

  // Latched request of every master
  logic [NUM_MASTERS-1:0] req_valid;
  logic [NUM_MASTERS-1:0] req_wr;
  logic [NUM_MASTERS-1:0] req_rd;
  logic [NUM_MASTERS-1:0] req_has_time;
  ctrlport_addr_t         req_addr    [NUM_MASTERS];
  ctrlport_data_t         req_data    [NUM_MASTERS];
  ctrlport_byte_en_t      req_byte_en [NUM_MASTERS];

  // Next slot in turn, wrapping after the last master
  assign sel_inc = (sel == SEL_W'(NUM_MASTERS - 1)) ? '0 : sel + 1'b1;

  // The slave has answered the request that is in flight
  assign slave_done = (arb_state == ARB_WAIT) && m_resp_ack;

  // ----------------------------------------
  // Input registers
  // ----------------------------------------

  // A strobe marks the slot valid; the slot is freed once the slave acks it
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      req_valid <= '0;
    end else begin
      if (slave_done) begin
        req_valid[sel] <= 1'b0;
      end
      // A fresh strobe wins over the clear of the same slot
      for (int i = 0; i < NUM_MASTERS; i++) begin
        if (s_req_wr[i] || s_req_rd[i]) begin
          req_valid[i] <= 1'b1;
        end
      end
    end
  end

  // Request fields are captured with every strobe and held until serviced
  always_ff @(posedge ctrlport_clk) begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (s_req_wr[i] || s_req_rd[i]) begin
        req_wr[i]       <= s_req_wr[i];
        req_rd[i]       <= s_req_rd[i];
        req_has_time[i] <= s_req_has_time[i];
        req_addr[i]     <= s_req_addr[i*ADDR_W +: ADDR_W];
        req_data[i]     <= s_req_data[i*DATA_W +: DATA_W];
        req_byte_en[i]  <= s_req_byte_en[i*BYTE_EN_W +: BYTE_EN_W];
      end
    end
  end

  // ----------------------------------------
  // Arbitration FSM
  // ----------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      arb_state <= ARB_SCAN;
      sel       <= '0;
    end else begin
      case (arb_state)
        ARB_SCAN: begin
          // Stop on a pending slot, otherwise look at the next master
          if (req_valid[sel]) begin
            arb_state <= ARB_LOAD;
          end else begin
            sel <= sel_inc;
          end
        end
        ARB_LOAD: begin
          arb_state <= ARB_WAIT;
        end
        ARB_WAIT: begin
          // Moving on after the ack keeps one master from being served twice
          if (m_resp_ack) begin
            arb_state <= ARB_SCAN;
            sel       <= sel_inc;
          end
        end
        default: begin
          arb_state <= ARB_SCAN;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Output registers
  // ----------------------------------------

  // The strobe toward the slave lasts exactly the cycle after ARB_LOAD
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      m_req_wr   <= 1'b0;
      m_req_rd   <= 1'b0;
      s_resp_ack <= '0;
    end else begin
      m_req_wr <= (arb_state == ARB_LOAD) && req_wr[sel];
      m_req_rd <= (arb_state == ARB_LOAD) && req_rd[sel];
      // Only the selected master sees the ack
      for (int i = 0; i < NUM_MASTERS; i++) begin
        s_resp_ack[i] <= slave_done && (sel == SEL_W'(i));
      end
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    if (arb_state == ARB_LOAD) begin
      m_req_addr     <= req_addr[sel];
      m_req_data     <= req_data[sel];
      m_req_byte_en  <= req_byte_en[sel];
      m_req_has_time <= req_has_time[sel];
    end
    // Status and read data go to every master, the ack qualifies them
    for (int i = 0; i < NUM_MASTERS; i++) begin
      s_resp_status[i*STATUS_W +: STATUS_W] <= m_resp_status;
      s_resp_data[i*DATA_W +: DATA_W]       <= m_resp_data;
    end
  end

endmodule

`default_nettype wire

// File: rtl/regfile_pkg.sv
// Register map of the control-port slave
`default_nettype none

package regfile_pkg;

  // Eight 32-bit words, so the word index is three bits wide
  localparam int unsigned REG_COUNT     = 8;
  localparam int unsigned REG_WORD_BITS = 3;

  // Low address bits that select a byte inside a word and are ignored
  localparam int unsigned REG_BYTE_BITS = 2;

  // Word index taken from byte address bits 4:2
  typedef logic [REG_WORD_BITS-1:0] reg_index_t;

  // Word 0 is the read-only identification word
  localparam reg_index_t REG_ID_WORD = '0;

  // Value returned by a read of the identification word
  localparam ctrlport_pkg::ctrlport_data_t REG_ID_VALUE = 32'hC0DE_0001;

endpackage

`default_nettype wire

// File: rtl/ctrlport_pkg.sv
// Control-port field definitions
`default_nettype none

package ctrlport_pkg;

  // ----------------------------------------
  // Field widths
  // ----------------------------------------

  // Byte address, data word and per-byte enables of one request
  localparam int unsigned ADDR_W    = 20;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned BYTE_EN_W = DATA_W / 8;

  // Every response carries a two-bit status
  localparam int unsigned STATUS_W  = 2;

  typedef logic [ADDR_W-1:0]    ctrlport_addr_t;
  typedef logic [DATA_W-1:0]    ctrlport_data_t;
  typedef logic [BYTE_EN_W-1:0] ctrlport_byte_en_t;
  typedef logic [STATUS_W-1:0]  ctrlport_status_t;

  // ----------------------------------------
  // Response status codes
  // ----------------------------------------

  localparam ctrlport_status_t STS_OKAY    = 2'd0;
  // Bad address or a write to a read-only word
  localparam ctrlport_status_t STS_CMDERR  = 2'd1;
  // Timed requests are not supported here
  localparam ctrlport_status_t STS_TSERR   = 2'd2;
  localparam ctrlport_status_t STS_WARNING = 2'd3;

  // Number of masters that share the register slave at the top level
  localparam int unsigned NUM_MASTERS = 3;

endpackage

`default_nettype wire
